/* src/dac_ctrl_pkg.sv */
package dac_ctrl_pkg;

  // Top two bits of every command word
  typedef enum logic [1:0] {
    op_no_op   = 2'b00,  // Delay or trigger wait
    op_dac_wr  = 2'b01,  // Four data words follow
    op_set_cal = 2'b10,  // Per-channel offset
    op_bad     = 2'b11   // Reserved, treated as error
  } cmd_op_e;

  typedef enum logic [2:0] {
    st_init      = 3'd0,
    st_idle      = 3'd1,
    st_delay     = 3'd2,
    st_trig_wait = 3'd3,
    st_dac_wr    = 3'd4,
    st_error     = 3'd5  // Sticky until reset
  } seq_state_e;

  // SPI register write, takes effect on ldac
  localparam logic [3:0] DAC_WRITE_CMD = 4'b0001;
  localparam int NUM_CHANNELS = 8;

  // NO_OP and DAC_WR view of a command word
  typedef struct packed {
    cmd_op_e     op;
    logic        do_ldac;    // Pulse ldac when the command completes
    logic        trig_wait;  // Wait for trigger instead of delay
    logic        cont;       // Another command must follow at once
    logic [1:0]  rsvd;
    logic [24:0] delay;      // Cycles, spent as delay+1
  } cmd_word_t;

  // SET_CAL view of a command word
  typedef struct packed {
    cmd_op_e            op;
    logic [10:0]        rsvd;
    logic [2:0]         chan;
    logic signed [15:0] value;  // Two's complement offset in LSBs
  } cal_word_t;

  // Two adjacent channels, chan is always even
  // code0 goes to chan, code1 to chan+1, both offset binary
  typedef struct packed {
    logic [2:0]  chan;
    logic [15:0] code1;
    logic [15:0] code0;
  } chan_pair_t;

  // Offset binary to signed, 32767 is midscale
  // 0xFFFF maps to +32768 and must be trapped by the caller
  function automatic logic signed [16:0] offset_to_signed(input logic [15:0] code);
    return $signed({1'b0, code}) - 17'sd32767;
  endfunction

  // Inverse of offset_to_signed, only valid for in-range values
  function automatic logic [15:0] signed_to_offset(input logic signed [16:0] val);
    logic signed [16:0] sum;
    sum = val + 17'sd32767;
    return sum[15:0];  // Top bit is zero when in range
  endfunction

  // Legal DAC span, symmetric around midscale
  function automatic logic code_in_range(input logic signed [16:0] val);
    return (val >= -17'sd32767) && (val <= 17'sd32767);
  endfunction

endpackage

/* src/cmd_sequencer.sv */
module cmd_sequencer #(
  parameter int SLOT_CYCLES = 128  // At least 104, one SPI pair per slot
) (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic [31:0]              cmd_word,
  input  logic                     cmd_buf_empty,
  input  logic                     trigger,
  input  logic                     cal_oob_hit,
  input  logic                     code_oob_hit,
  output logic                     cmd_word_rd_en,
  output logic                     pair_load,
  output dac_ctrl_pkg::chan_pair_t pair_raw,
  output logic                     cal_wr,
  output dac_ctrl_pkg::cal_word_t  cal_cmd,
  output logic                     abort,
  output logic                     setup_done,
  output logic                     waiting_for_trigger,
  output logic                     ldac,
  output logic                     bad_cmd,
  output logic                     unexp_trig,
  output logic                     cmd_buf_underflow,
  output logic                     cal_oob,
  output logic                     dac_val_oob
);
  import dac_ctrl_pkg::*;

  localparam int SLOT_W = $clog2(SLOT_CYCLES);
  localparam logic [SLOT_W-1:0] SLOT_LAST = SLOT_W'(SLOT_CYCLES - 1);

  seq_state_e        state;
  cmd_word_t         cmd;       // Decoded view of the word at the buffer head
  logic [24:0]       timer;
  logic [SLOT_W-1:0] slot_cnt;
  logic [1:0]        pair_idx;  // Which data word of the DAC_WR
  logic              lat_ldac;
  logic              lat_trig;
  logic              lat_cont;

  logic wait_done;
  logic cmd_take;
  logic cmd_pop;
  logic data_pop;
  logic write_end;
  logic timed_op;
  logic code_ffff;
  logic err_bad;
  logic err_trig;
  logic err_uflow;
  logic err_val;
  logic err_any;

  assign cmd = cmd_word_t'(cmd_word);

  // Delay or trigger wait has run out
  assign wait_done = (state == st_delay && timer == '0) ||
                     (state == st_trig_wait && trigger);
  assign cmd_take  = (state == st_idle) || wait_done;  // Ready for the next command
  assign cmd_pop   = cmd_take && !cmd_buf_empty;
  assign data_pop  = (state == st_dac_wr) && (slot_cnt == '0);  // Slot start
  assign write_end = (state == st_dac_wr) && (slot_cnt == SLOT_LAST) && (pair_idx == 2'd3);
  assign timed_op  = (cmd.op == op_no_op) || (cmd.op == op_dac_wr);

  assign cmd_word_rd_en = !cmd_buf_empty && (cmd_take || data_pop);

  // Data word view, low half is the even channel
  assign code_ffff = (cmd_word[15:0] == 16'hFFFF) || (cmd_word[31:16] == 16'hFFFF);
  assign pair_load = data_pop && !cmd_buf_empty && !code_ffff;
  assign pair_raw.chan  = {pair_idx, 1'b0};
  assign pair_raw.code0 = cmd_word[15:0];
  assign pair_raw.code1 = cmd_word[31:16];

  // SET_CAL is handed over in the pop cycle
  assign cal_wr  = cmd_pop && (cmd.op == op_set_cal);
  assign cal_cmd = cal_word_t'(cmd_word);

  // Error sources
  assign err_bad   = cmd_pop && (cmd.op == op_bad);
  assign err_trig  = trigger && (state != st_trig_wait) && (state != st_error);
  assign err_uflow = cmd_buf_empty && (data_pop || (wait_done && lat_cont));
  assign err_val   = (data_pop && !cmd_buf_empty && code_ffff) || code_oob_hit;
  assign err_any   = err_bad || err_trig || err_uflow || err_val || cal_oob_hit;

  assign abort               = (state == st_error);  // Flushes pipeline and shifter
  assign waiting_for_trigger = (state == st_trig_wait);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= st_init;
    end else if (state != st_error) begin  // Error is terminal
      if (err_any) begin
        state <= st_error;
      end else if (state == st_init) begin
        state <= st_idle;
      end else if (cmd_pop) begin
        // Decode straight from the head word
        case (cmd.op)
          op_no_op:  state <= cmd.trig_wait ? st_trig_wait : st_delay;
          op_dac_wr: state <= st_dac_wr;
          default:   state <= st_idle;  // SET_CAL completes in the pop cycle
        endcase
      end else if (wait_done) begin
        state <= st_idle;  // Nothing queued
      end else if (write_end) begin
        state <= lat_trig ? st_trig_wait : st_delay;  // Tail of the DAC_WR
      end
    end
  end

  // Command bits kept for the whole command
  always_ff @(posedge clk) begin
    if (!resetn) begin
      lat_ldac <= 1'b0;
      lat_trig <= 1'b0;
      lat_cont <= 1'b0;
    end else if (cmd_pop) begin
      lat_ldac <= timed_op && cmd.do_ldac;
      lat_trig <= timed_op && cmd.trig_wait;
      lat_cont <= timed_op && cmd.cont;
    end
  end

  // Loaded at pop, only counts in st_delay
  // so a DAC_WR keeps its delay across the write phase
  always_ff @(posedge clk) begin
    if (!resetn) begin
      timer <= '0;
    end else if (cmd_pop && timed_op) begin
      timer <= cmd.delay;
    end else if (state == st_delay && timer != '0) begin
      timer <= timer - 25'd1;
    end
  end

  // Slot schedule, four slots of SLOT_CYCLES each
  always_ff @(posedge clk) begin
    if (!resetn) begin
      slot_cnt <= '0;
      pair_idx <= '0;
    end else if (cmd_pop) begin
      slot_cnt <= '0;  // First slot starts right after the pop
      pair_idx <= '0;
    end else if (state == st_dac_wr) begin
      if (slot_cnt == SLOT_LAST) begin
        slot_cnt <= '0;
        pair_idx <= pair_idx + 2'd1;
      end else begin
        slot_cnt <= slot_cnt + 1'b1;
      end
    end
  end

  // Sticky error flags
  always_ff @(posedge clk) begin
    if (!resetn) begin
      bad_cmd           <= 1'b0;
      unexp_trig        <= 1'b0;
      cmd_buf_underflow <= 1'b0;
      cal_oob           <= 1'b0;
      dac_val_oob       <= 1'b0;
    end else begin
      if (err_bad) bad_cmd <= 1'b1;
      if (err_trig) unexp_trig <= 1'b1;
      if (err_uflow) cmd_buf_underflow <= 1'b1;
      if (cal_oob_hit) cal_oob <= 1'b1;
      if (err_val) dac_val_oob <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      setup_done <= 1'b0;
    end else if (err_any || state == st_error) begin
      setup_done <= 1'b0;
    end else if (state == st_init) begin
      setup_done <= 1'b1;  // High from the first idle cycle on
    end
  end

  // One cycle, right after the command completes
  always_ff @(posedge clk) begin
    if (!resetn) begin
      ldac <= 1'b0;
    end else begin
      ldac <= wait_done && lat_ldac && !err_any;
    end
  end

endmodule

/* src/cal_pipeline.sv */
module cal_pipeline #(
  parameter int ABS_CAL_MAX = 4096  // Largest accepted calibration magnitude
) (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     abort,
  input  logic                     cal_wr,
  input  dac_ctrl_pkg::cal_word_t  cal_cmd,
  input  logic                     pair_load,
  input  dac_ctrl_pkg::chan_pair_t pair_raw,
  output logic                     pair_valid,
  output dac_ctrl_pkg::chan_pair_t pair_cal,
  output logic                     cal_oob_hit,
  output logic                     code_oob_hit
);
  import dac_ctrl_pkg::*;

  logic signed [15:0] cal_val [NUM_CHANNELS];  // One offset per channel
  logic               cal_ok;
  logic [2:0]         chan_odd;

  // Stage 1 registers
  logic               s1_valid;
  logic [2:0]         s1_chan;
  logic signed [16:0] s1_sum0;
  logic signed [16:0] s1_sum1;
  logic               s1_ok;

  // Magnitude check on the incoming SET_CAL value
  assign cal_ok = (int'($signed(cal_cmd.value)) <= ABS_CAL_MAX) &&
                  (int'($signed(cal_cmd.value)) >= -ABS_CAL_MAX);
  assign cal_oob_hit = cal_wr && !cal_ok;  // Same cycle as the write

  // Calibration store, out-of-range writes are dropped
  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < NUM_CHANNELS; i++) begin
        cal_val[i] <= '0;
      end
    end else if (cal_wr && cal_ok) begin
      cal_val[cal_cmd.chan] <= cal_cmd.value;
    end
  end

  // Second channel of the pair, chan is even
  assign chan_odd = {pair_raw.chan[2:1], 1'b1};

  // Stage 1, add calibration
  always_ff @(posedge clk) begin
    if (!resetn) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= pair_load && !abort;
    end
  end

  always_ff @(posedge clk) begin
    if (pair_load) begin
      s1_chan <= pair_raw.chan;
      s1_sum0 <= offset_to_signed(pair_raw.code0) + cal_val[pair_raw.chan];
      s1_sum1 <= offset_to_signed(pair_raw.code1) + cal_val[chan_odd];
    end
  end

  // Stage 2, range check and back to offset binary
  assign s1_ok = code_in_range(s1_sum0) && code_in_range(s1_sum1);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      pair_valid   <= 1'b0;
      code_oob_hit <= 1'b0;
    end else begin
      pair_valid   <= s1_valid && s1_ok && !abort;
      code_oob_hit <= s1_valid && !s1_ok && !abort;  // Whole pair rejected
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      pair_cal.chan  <= s1_chan;
      pair_cal.code0 <= signed_to_offset(s1_sum0);
      pair_cal.code1 <= signed_to_offset(s1_sum1);
    end
  end

endmodule

/* src/spi_frame_shifter.sv */
module spi_frame_shifter (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     abort,
  input  logic                     pair_valid,
  input  dac_ctrl_pkg::chan_pair_t pair_cal,
  output logic                     n_cs,
  output logic                     sck,
  output logic                     mosi
);
  import dac_ctrl_pkg::*;

  logic [23:0] sh;        // Frame on the wire, MSB first
  logic [23:0] frame_b;   // Second frame, waits for the gap
  logic        busy;
  logic        gap;       // Two cycles with n_cs high between frames
  logic        second;    // Shifting frame b
  logic        phase;     // Half-bit, sck high when set
  logic [4:0]  bit_cnt;
  logic        in_frame;

  // Command, zero bit, channel, code
  function automatic logic [23:0] build_frame(input logic [2:0] chan,
                                              input logic [15:0] code);
    return {DAC_WRITE_CMD, 1'b0, chan, code};
  endfunction

  assign in_frame = busy && !gap;
  assign n_cs     = !in_frame;
  assign sck      = in_frame && phase;   // Rises mid-bit, DAC samples here
  assign mosi     = in_frame && sh[23];

  // Bit and gap sequencing
  always_ff @(posedge clk) begin
    if (!resetn || abort) begin
      busy    <= 1'b0;
      gap     <= 1'b0;
      second  <= 1'b0;
      phase   <= 1'b0;
      bit_cnt <= '0;
    end else if (pair_valid) begin
      busy    <= 1'b1;  // First frame starts next cycle
      gap     <= 1'b0;
      second  <= 1'b0;
      phase   <= 1'b0;
      bit_cnt <= '0;
    end else if (busy) begin
      phase <= ~phase;
      if (gap) begin
        if (phase) gap <= 1'b0;
      end else if (phase) begin
        if (bit_cnt == 5'd23) begin
          bit_cnt <= '0;
          if (second) begin
            busy <= 1'b0;  // Pair done
          end else begin
            gap    <= 1'b1;
            second <= 1'b1;
          end
        end else begin
          bit_cnt <= bit_cnt + 5'd1;
        end
      end
    end
  end

  // Shift on the falling half of sck
  always_ff @(posedge clk) begin
    if (pair_valid) begin
      sh      <= build_frame(pair_cal.chan, pair_cal.code0);
      frame_b <= build_frame({pair_cal.chan[2:1], 1'b1}, pair_cal.code1);
    end else if (in_frame && phase) begin
      if (bit_cnt == 5'd23) sh <= frame_b;  // Ready before the gap ends
      else sh <= {sh[22:0], 1'b0};
    end
  end

endmodule

/* src/dac_ctrl_top.sv */
module dac_ctrl_top #(
  parameter int ABS_CAL_MAX = 4096,
  parameter int SLOT_CYCLES = 128
) (
  input  logic        clk,
  input  logic        resetn,
  input  logic [31:0] cmd_word,
  input  logic        cmd_buf_empty,
  output logic        cmd_word_rd_en,
  input  logic        trigger,
  output logic        setup_done,
  output logic        waiting_for_trigger,
  output logic        bad_cmd,
  output logic        unexp_trig,
  output logic        cmd_buf_underflow,
  output logic        cal_oob,
  output logic        dac_val_oob,
  output logic        n_cs,
  output logic        sck,
  output logic        mosi,
  output logic        ldac
);
  import dac_ctrl_pkg::*;

  chan_pair_t pair_raw;    // Sequencer to pipeline
  chan_pair_t pair_cal;    // Pipeline to shifter
  cal_word_t  cal_cmd;
  logic       pair_load;
  logic       pair_valid;
  logic       cal_wr;
  logic       abort;       // High for as long as the sequencer sits in error
  logic       cal_oob_hit;
  logic       code_oob_hit;

  // Input side, owns state and error flags
  cmd_sequencer #(
    .SLOT_CYCLES (SLOT_CYCLES)
  ) u_seq (
    .clk                 (clk),
    .resetn              (resetn),
    .cmd_word            (cmd_word),
    .cmd_buf_empty       (cmd_buf_empty),
    .trigger             (trigger),
    .cal_oob_hit         (cal_oob_hit),
    .code_oob_hit        (code_oob_hit),
    .cmd_word_rd_en      (cmd_word_rd_en),
    .pair_load           (pair_load),
    .pair_raw            (pair_raw),
    .cal_wr              (cal_wr),
    .cal_cmd             (cal_cmd),
    .abort               (abort),
    .setup_done          (setup_done),
    .waiting_for_trigger (waiting_for_trigger),
    .ldac                (ldac),
    .bad_cmd             (bad_cmd),
    .unexp_trig          (unexp_trig),
    .cmd_buf_underflow   (cmd_buf_underflow),
    .cal_oob             (cal_oob),
    .dac_val_oob         (dac_val_oob)
  );

  // Two-stage calibration
  cal_pipeline #(
    .ABS_CAL_MAX (ABS_CAL_MAX)
  ) u_cal (
    .clk          (clk),
    .resetn       (resetn),
    .abort        (abort),
    .cal_wr       (cal_wr),
    .cal_cmd      (cal_cmd),
    .pair_load    (pair_load),
    .pair_raw     (pair_raw),
    .pair_valid   (pair_valid),
    .pair_cal     (pair_cal),
    .cal_oob_hit  (cal_oob_hit),
    .code_oob_hit (code_oob_hit)
  );

  // DAC side
  spi_frame_shifter u_spi (
    .clk        (clk),
    .resetn     (resetn),
    .abort      (abort),
    .pair_valid (pair_valid),
    .pair_cal   (pair_cal),
    .n_cs       (n_cs),
    .sck        (sck),
    .mosi       (mosi)
  );

endmodule

/* bench/tb_dac_ctrl.sv */
module tb_dac_ctrl;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ABS_CAL_MAX = 4096;
  localparam int SLOT_CYCLES = 128;
  // Two bursts and four error runs each span a write phase, then margin
  localparam int TIMEOUT_CYCLES = 10 * 4 * SLOT_CYCLES + 800;

  logic        clk = 1'b0;
  logic        resetn = 1'b0;
  logic [31:0] cmd_word = '0;
  logic        cmd_buf_empty = 1'b1;
  logic        trigger = 1'b0;
  logic        cmd_word_rd_en, setup_done, waiting_for_trigger;
  logic        bad_cmd, unexp_trig, cmd_buf_underflow, cal_oob, dac_val_oob;
  logic        n_cs, sck, mosi, ldac;
  logic        any_err;

  logic [31:0]        buf_q[$];       // Command buffer contents, head first
  logic [23:0]        exp_q[$];       // Predicted SPI frames
  int                 pop_cycles[$];  // Cycle of each buffer pop
  logic signed [15:0] cal_model [8];
  logic [31:0]        lfsr = 32'he9ed;
  logic [23:0]        rx;
  logic [23:0]        exp_frame;
  logic               prev_ncs = 1'b1;
  logic               prev_sck = 1'b0;
  int rx_bits = 0;
  int cs_low = 0;  // Cycles with n_cs low in the current frame
  int errors = 0;
  int checks = 0;
  int cycle = 0;
  int ldac_cnt = 0;
  int ldac_cycle = 0;
  int frame_end_cycle = 0;

  assign any_err = bad_cmd | unexp_trig | cmd_buf_underflow | cal_oob | dac_val_oob;

  dac_ctrl_top u_dut (.*);

  initial begin
    forever #20 clk = ~clk;
  end

  task automatic log_error(input string msg);
    errors++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  task automatic check_that(input bit ok, input string msg);
    checks++;
    assert (ok) else log_error(msg);
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hB4BCD35C) : (lfsr >> 1);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] cmd_fn(input logic [1:0] op, input logic do_ldac,
                                         input logic trig, input logic [24:0] delay);
    return {op, do_ldac, trig, 1'b0, 2'b00, delay};
  endfunction

  // Write command 0001, zero bit, channel, raw code plus offset
  function automatic logic [23:0] expected_frame(input logic [2:0] chan, input logic [15:0] raw);
    return {4'b0001, 1'b0, chan, 16'(int'(raw) + int'(cal_model[chan]))};
  endfunction

  function automatic bit flag_set(input int sel);
    case (sel)
      0: return cal_oob;
      1: return bad_cmd;
      2: return dac_val_oob;
      default: return cmd_buf_underflow;
    endcase
  endfunction

  // FWFT buffer, head moves one cycle after the pop
  always @(posedge clk) begin
    if (cmd_word_rd_en === 1'b1 && buf_q.size() > 0) begin
      void'(buf_q.pop_front());
      pop_cycles.push_back(cycle);
    end
    cmd_buf_empty <= (buf_q.size() == 0);
    cmd_word      <= (buf_q.size() > 0) ? buf_q[0] : 32'h0;
  end

  // Frame decoder, sample mosi on each sck rise inside n_cs
  always @(posedge clk) begin
    if (!resetn) begin
      rx_bits = 0;
      cs_low  = 0;
    end
    if (!n_cs) cs_low++;
    if (!n_cs && sck && !prev_sck) begin
      rx = {rx[22:0], mosi};
      rx_bits++;
    end
    if (n_cs && !prev_ncs) begin  // End of frame
      frame_end_cycle = cycle;
      assert (rx_bits == 24) else log_error($sformatf("frame had %0d sck pulses", rx_bits));
      assert (cs_low == 48) else log_error($sformatf("n_cs low for %0d cycles", cs_low));
      if (exp_q.size() == 0) begin
        log_error("frame seen with none expected");
      end else begin
        exp_frame = exp_q.pop_front();
        assert (rx == exp_frame)
          else log_error($sformatf("frame %h, expected %h", rx, exp_frame));
      end
      rx_bits = 0;
      cs_low  = 0;
    end
    if (ldac === 1'b1) begin
      ldac_cnt++;
      ldac_cycle = cycle;
    end
    prev_ncs = n_cs;
    prev_sck = sck;
  end

  assert property (@(posedge clk) disable iff (!resetn) ldac |=> !ldac)
    else log_error("ldac high for more than one cycle");
  assert property (@(posedge clk) disable iff (!resetn) ldac |-> !any_err)
    else log_error("ldac pulsed with an error flag set");
  // Data set up a half bit ahead of the sampling edge
  assert property (@(posedge clk) disable iff (!resetn) $rose(sck) |-> $stable(mosi))
    else log_error("mosi changed on the rising edge of sck");

  always @(negedge clk) begin
    cycle++;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic apply_reset;
    @(posedge clk);
    resetn  <= 1'b0;
    trigger <= 1'b0;
    @(negedge clk);
    buf_q.delete();
    exp_q.delete();
    pop_cycles.delete();
    foreach (cal_model[i]) cal_model[i] = '0;
    repeat (2) @(posedge clk);
    resetn <= 1'b1;
  endtask

  task automatic set_cal(input logic [2:0] chan, input logic signed [15:0] value);
    @(negedge clk);
    buf_q.push_back({2'b10, 11'd0, chan, value});
    cal_model[chan] = value;
  endtask

  // DAC_WR plus four words, codes kept clear of 0xFFFF and the range ends
  task automatic dac_burst(input logic do_ldac);
    logic [15:0] lo;
    logic [15:0] hi;
    @(negedge clk);
    buf_q.push_back(cmd_fn(2'b01, do_ldac, 1'b0, 25'd3));
    for (int p = 0; p < 4; p++) begin
      lo = 16'(32'd16384 + random_bits(15));
      hi = 16'(32'd16384 + random_bits(15));
      buf_q.push_back({hi, lo});
      exp_q.push_back(expected_frame(3'(2 * p), lo));
      exp_q.push_back(expected_frame(3'(2 * p + 1), hi));
    end
  endtask

  task automatic error_run(input logic [31:0] w0, input logic [31:0] w1, input bit two_words,
                           input int sel, input string name);
    apply_reset();
    do @(negedge clk); while (setup_done !== 1'b1);
    ldac_cnt = 0;
    buf_q.push_back(w0);
    if (two_words) buf_q.push_back(w1);
    while (!flag_set(sel)) @(negedge clk);
    check_that(!setup_done, {name, " left setup_done high"});
    repeat (4 * SLOT_CYCLES + 8) @(negedge clk);  // Longer than a write phase
    check_that(ldac_cnt == 0, {name, " run still pulsed ldac"});
  endtask

  initial begin
    apply_reset();
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_that(setup_done === 1'b1, "setup_done not high 2 cycles after reset");
    check_that(!any_err, "error flag set after reset");

    // Delay 9 then delay 0, next pop 10 cycles later
    buf_q.push_back(cmd_fn(2'b00, 1'b0, 1'b0, 25'd9));
    buf_q.push_back(cmd_fn(2'b00, 1'b0, 1'b0, 25'd0));
    while (pop_cycles.size() < 2) begin
      @(negedge clk);
      check_that(!waiting_for_trigger, "waiting_for_trigger high during a delay");
    end
    check_that(pop_cycles[1] - pop_cycles[0] == 10,
               $sformatf("delay 9 popped after %0d cycles", pop_cycles[1] - pop_cycles[0]));

    set_cal(3'd1, 16'sd300);
    set_cal(3'd2, -16'sd1200);
    set_cal(3'd5, 16'sd4096);
    dac_burst(1'b0);
    while (exp_q.size() != 0) @(negedge clk);
    check_that(!any_err, "error flag set during calibrated write");

    ldac_cnt = 0;
    dac_burst(1'b1);
    while (ldac_cnt == 0) @(negedge clk);
    check_that(exp_q.size() == 0, "ldac came before all frames");
    check_that(ldac_cycle > frame_end_cycle, "ldac not after last n_cs rise");
    @(negedge clk);
    buf_q.push_back(cmd_fn(2'b00, 1'b0, 1'b1, 25'd0));  // Trigger wait
    while (!waiting_for_trigger) @(negedge clk);
    check_that(ldac_cnt == 1, $sformatf("%0d ldac pulses for one write", ldac_cnt));
    @(posedge clk);
    trigger <= 1'b1;
    @(posedge clk);
    trigger <= 1'b0;
    @(negedge clk);
    check_that(!waiting_for_trigger && !unexp_trig, "trigger did not end the wait cleanly");

    // Trigger while idle
    @(posedge clk);
    trigger <= 1'b1;
    @(posedge clk);
    trigger <= 1'b0;
    @(negedge clk);
    check_that(unexp_trig && !setup_done, "stray trigger not flagged");
    apply_reset();
    do @(negedge clk); while (setup_done !== 1'b1);
    check_that(!any_err, "reset did not clear unexp_trig");

    // A queued NO_OP with ldac must never run once the error is taken
    error_run({2'b10, 11'd0, 3'd0, 16'(ABS_CAL_MAX + 1)}, cmd_fn(2'b00, 1'b1, 1'b0, 25'd0),
              1'b1, 0, "cal_oob");
    error_run({2'b11, 30'd0}, cmd_fn(2'b00, 1'b1, 1'b0, 25'd0), 1'b1, 1, "bad_cmd");
    error_run(cmd_fn(2'b01, 1'b1, 1'b0, 25'd2), {16'h8000, 16'hFFFF}, 1'b1, 2, "dac_val_oob");
    error_run(cmd_fn(2'b01, 1'b1, 1'b0, 25'd2), '0, 1'b0, 3, "cmd_buf_underflow");

    $display("Summary: %0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* filelist.f */
src/dac_ctrl_pkg.sv
src/cmd_sequencer.sv
src/cal_pipeline.sv
src/spi_frame_shifter.sv
src/dac_ctrl_top.sv
bench/tb_dac_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the DAC controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_dac_ctrl -f filelist.f -o sim_dac_ctrl

./obj_dir/sim_dac_ctrl > sim.log 2>&1 || true
cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
